//--- list.f
verilog/glb_pkg.sv
verilog/bank_mem_if.sv
verilog/bank_memory.sv
verilog/bank_controller.sv
verilog/glb_bank.sv
sim/tb_glb_bank.sv

//--- run_sim.sh
#!/bin/sh
# Build the bank testbench with Verilator and run it.
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f list.f --top-module tb_glb_bank \
        -o tb_glb_bank \
    && ./obj_dir/tb_glb_bank \
    || exit 1

//--- sim/tb_glb_bank.sv
// Global buffer bank testbench.
// Directed tests plus LCG traffic against a cycle model of the
// fixed-priority arbiter, the memory and the held read ports.

`timescale 1ns/10ps

module tb_glb_bank
    import glb_pkg::*;
();

    localparam int MEM_DEPTH = 2 ** BANK_ADDR_WIDTH;
    localparam int WATCHDOG_CYCLES = 10000;  // Tests need about 3300 cycles.

    logic       clk = 1'b0;
    logic       reset;
    logic       host_wr_en, host_rd_en, cgra_wr_en, cgra_rd_en, cfg_rd_en;
    bank_addr_t host_wr_addr, host_rd_addr, cgra_wr_addr, cgra_rd_addr, cfg_rd_addr;
    bank_data_t host_wr_data, cgra_wr_data;
    bank_data_t host_rd_data, cgra_rd_data, cfg_rd_data;

    // Requests for the next cycle, set by the tests.
    logic       req_host_wr_en, req_host_rd_en, req_cgra_wr_en, req_cgra_rd_en, req_cfg_rd_en;
    bank_addr_t req_host_wr_addr, req_host_rd_addr, req_cgra_wr_addr;
    bank_addr_t req_cgra_rd_addr, req_cfg_rd_addr;
    bank_data_t req_host_wr_data, req_cgra_wr_data;

    // ==============================
    // Reference model
    // ==============================
    bank_data_t  model_mem [MEM_DEPTH];
    bank_data_t  exp_host, exp_cgra, exp_cfg;  // Expected held read ports.
    logic [31:0] lcg_state = 32'h5506_e60d;

    always #20 clk = ~clk;  // 40 ns period.

    glb_bank dut0 (.*);

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Ten address bits from the middle of the LCG word.
    function automatic bank_addr_t random_addr();
        logic [31:0] v;
        v = lcg_next();
        return v[21:12];
    endfunction

    // Every word differs and depends on all address bits.
    function automatic bank_data_t fill_word(bank_addr_t a);
        return {a, ~a, a ^ 10'h155, 34'h25a5ac3c3};
    endfunction

    function automatic bank_data_t pattern_word(int i);
        return {16'hface, 16'(i), 32'hc0de_0000 | 32'(i * 7)};
    endfunction

    // Fixed priority of the bank controller.
    function automatic glb_req_e predict_winner();
        if (req_host_wr_en) return REQ_HOST_WR;
        if (req_host_rd_en) return REQ_HOST_RD;
        if (req_cfg_rd_en)  return REQ_CFG_RD;
        if (req_cgra_wr_en) return REQ_CGRA_WR;
        if (req_cgra_rd_en) return REQ_CGRA_RD;
        return REQ_NONE;
    endfunction

    task automatic apply_model();
        case (predict_winner())
            REQ_HOST_WR: model_mem[req_host_wr_addr] = req_host_wr_data;
            REQ_HOST_RD: exp_host = model_mem[req_host_rd_addr];
            REQ_CFG_RD:  exp_cfg  = model_mem[req_cfg_rd_addr];
            REQ_CGRA_WR: model_mem[req_cgra_wr_addr] = req_cgra_wr_data;
            REQ_CGRA_RD: exp_cgra = model_mem[req_cgra_rd_addr];
            default: ;  // Idle cycle.
        endcase
    endtask

    task automatic clear_requests();
        req_host_wr_en = 1'b0;
        req_host_rd_en = 1'b0;
        req_cgra_wr_en = 1'b0;
        req_cgra_rd_en = 1'b0;
        req_cfg_rd_en  = 1'b0;
        req_host_wr_addr = '0;
        req_host_rd_addr = '0;
        req_cgra_wr_addr = '0;
        req_cgra_rd_addr = '0;
        req_cfg_rd_addr  = '0;
        req_host_wr_data = '0;
        req_cgra_wr_data = '0;
    endtask

    // ==============================
    // Compare tasks
    // ==============================
    task automatic check_data(input string name, input bank_data_t actual,
                              input bank_data_t expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s expected %h actual %h",
                     $time, name, expected, actual);
            $display("tests failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic check_grant_rd();
        check_data("host_rd_data", host_rd_data, exp_host);
        check_data("cgra_rd_data", cgra_rd_data, exp_cgra);
        check_data("cfg_rd_data", cfg_rd_data, exp_cfg);
    endtask

    // One bus cycle. Outputs at the negedge reflect last cycle's grant.
    task automatic step();
        @(posedge clk);
        host_wr_en   <= req_host_wr_en;
        host_wr_addr <= req_host_wr_addr;
        host_wr_data <= req_host_wr_data;
        host_rd_en   <= req_host_rd_en;
        host_rd_addr <= req_host_rd_addr;
        cgra_wr_en   <= req_cgra_wr_en;
        cgra_wr_addr <= req_cgra_wr_addr;
        cgra_wr_data <= req_cgra_wr_data;
        cgra_rd_en   <= req_cgra_rd_en;
        cgra_rd_addr <= req_cgra_rd_addr;
        cfg_rd_en    <= req_cfg_rd_en;
        cfg_rd_addr  <= req_cfg_rd_addr;
        @(negedge clk);
        check_grant_rd();
        apply_model();
        clear_requests();
    endtask

    // ==============================
    // Directed tests
    // ==============================
    task automatic test_reset_and_fill();
        check_data("host_rd_data", host_rd_data, '0);
        check_data("cgra_rd_data", cgra_rd_data, '0);
        check_data("cfg_rd_data", cfg_rd_data, '0);
        for (int a = 0; a < MEM_DEPTH; a++) begin  // Known contents everywhere.
            req_host_wr_en   = 1'b1;
            req_host_wr_addr = bank_addr_t'(a);
            req_host_wr_data = fill_word(bank_addr_t'(a));
            step();
        end
    endtask

    task automatic test_host_wr_rd();
        bank_addr_t a;
        for (int i = 0; i < 64; i++) begin
            a = (i == 63) ? 10'h3ff : bank_addr_t'(i * 16);  // 0 up to top address.
            req_host_wr_en   = 1'b1;
            req_host_wr_addr = a;
            req_host_wr_data = pattern_word(i);
            step();
        end
        for (int i = 0; i < 64; i++) begin
            req_host_rd_en   = 1'b1;
            req_host_rd_addr = (i == 63) ? 10'h3ff : bank_addr_t'(i * 16);
            step();
            if (i > 0) check_data("host_rd_data", host_rd_data, pattern_word(i - 1));
        end
        step();
        check_data("host_rd_data", host_rd_data, pattern_word(63));
    endtask

    task automatic test_cross_visibility();
        bank_data_t held;
        for (int i = 0; i < 16; i++) begin  // CGRA writes, host reads back.
            req_cgra_wr_en   = 1'b1;
            req_cgra_wr_addr = bank_addr_t'(10'h181 + i);
            req_cgra_wr_data = {16'hc9a0, 16'(i), 32'h1234_5678 ^ 32'(i)};
            step();
            req_host_rd_en   = 1'b1;
            req_host_rd_addr = bank_addr_t'(10'h181 + i);
            step();
            step();
            check_data("host_rd_data", host_rd_data,
                       {16'hc9a0, 16'(i), 32'h1234_5678 ^ 32'(i)});
        end
        for (int i = 0; i < 8; i++) begin  // Config reads host data.
            held = host_rd_data;
            req_cfg_rd_en   = 1'b1;
            req_cfg_rd_addr = bank_addr_t'(i * 16);
            step();
            step();
            check_data("cfg_rd_data", cfg_rd_data, pattern_word(i));
            check_data("host_rd_data", host_rd_data, held);
        end
    endtask

    task automatic test_priority();
        bank_data_t old_cfg;
        bank_data_t old_cgra;
        req_host_wr_en   = 1'b1;  // Host must win on a shared address.
        req_host_wr_addr = 10'h200;
        req_host_wr_data = 64'h0123_4567_89ab_cdef;
        req_cgra_wr_en   = 1'b1;
        req_cgra_wr_addr = 10'h200;
        req_cgra_wr_data = 64'hdead_beef_dead_beef;
        step();
        req_host_rd_en   = 1'b1;
        req_host_rd_addr = 10'h200;
        step();
        step();
        check_data("host_rd_data", host_rd_data, 64'h0123_4567_89ab_cdef);
        old_cfg  = cfg_rd_data;  // Three reads at once.
        old_cgra = cgra_rd_data;
        req_host_rd_en   = 1'b1;
        req_host_rd_addr = 10'h3ff;
        req_cfg_rd_en    = 1'b1;
        req_cfg_rd_addr  = 10'h010;
        req_cgra_rd_en   = 1'b1;
        req_cgra_rd_addr = 10'h020;
        step();
        step();
        check_data("host_rd_data", host_rd_data, pattern_word(63));
        check_data("cfg_rd_data", cfg_rd_data, old_cfg);
        check_data("cgra_rd_data", cgra_rd_data, old_cgra);
        req_cfg_rd_en    = 1'b1;  // Config read drops the CGRA write.
        req_cfg_rd_addr  = 10'h000;
        req_cgra_wr_en   = 1'b1;
        req_cgra_wr_addr = 10'h2f1;
        req_cgra_wr_data = 64'hbad0_bad0_bad0_bad0;
        step();
        req_host_rd_en   = 1'b1;
        req_host_rd_addr = 10'h2f1;
        step();
        step();
        check_data("cfg_rd_data", cfg_rd_data, pattern_word(0));
        check_data("host_rd_data", host_rd_data, fill_word(10'h2f1));
    endtask

    task automatic test_hold();
        req_cgra_rd_en   = 1'b1;
        req_cgra_rd_addr = 10'h3ff;
        step();
        step();
        check_data("cgra_rd_data", cgra_rd_data, pattern_word(63));
        for (int i = 0; i < 12; i++) begin  // Idle cycles, then reads by others.
            req_host_rd_en   = (i >= 5) && (i < 8);
            req_host_rd_addr = bank_addr_t'(i * 16);
            req_cfg_rd_en    = (i >= 8);
            req_cfg_rd_addr  = bank_addr_t'(i * 32);
            step();
            check_data("cgra_rd_data", cgra_rd_data, pattern_word(63));
        end
    endtask

    task automatic test_random();
        logic [31:0] r;
        for (int n = 0; n < 2000; n++) begin
            r = lcg_next();
            req_host_wr_en   = r[4] & r[5];  // Sparse enables let lower priorities win.
            req_host_rd_en   = r[6] & r[7];
            req_cfg_rd_en    = r[8] & r[9];
            req_cgra_wr_en   = r[10];
            req_cgra_rd_en   = r[11];
            req_host_wr_addr = random_addr();
            req_host_rd_addr = random_addr();
            req_cgra_wr_addr = random_addr();
            req_cgra_rd_addr = random_addr();
            req_cfg_rd_addr  = random_addr();
            req_host_wr_data = {lcg_next(), lcg_next()};
            req_cgra_wr_data = {lcg_next(), lcg_next()};
            step();
        end
        step();
        step();
    endtask

    // ==============================
    // Run and watchdog
    // ==============================
    initial begin
        reset <= 1'b1;
        clear_requests();
        host_wr_en   <= 1'b0;
        host_rd_en   <= 1'b0;
        cfg_rd_en    <= 1'b0;
        cgra_wr_en   <= 1'b0;
        cgra_rd_en   <= 1'b0;
        host_wr_addr <= '0;
        host_rd_addr <= '0;
        cfg_rd_addr  <= '0;
        cgra_wr_addr <= '0;
        cgra_rd_addr <= '0;
        host_wr_data <= '0;
        cgra_wr_data <= '0;
        exp_host = '0;
        exp_cgra = '0;
        exp_cfg  = '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        test_reset_and_fill();
        test_host_wr_rd();
        test_cross_visibility();
        test_priority();
        test_hold();
        test_random();
        $display("all tests passed");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("run timed out after %0d cycles", WATCHDOG_CYCLES);
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- verilog/bank_controller.sv
// Bank controller.
// Grants the single memory port to one of host, config and CGRA
// requests in fixed priority, then routes read data back to the
// winner and holds each read port until its next granted read.

`timescale 1ns/10ps

module bank_controller
    import glb_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    // Host requests.
    input  logic        host_wr_en,
    input  bank_addr_t  host_wr_addr,
    input  bank_data_t  host_wr_data,
    input  logic        host_rd_en,
    input  bank_addr_t  host_rd_addr,
    output bank_data_t  host_rd_data,

    // Fabric requests.
    input  logic        cgra_wr_en,
    input  bank_addr_t  cgra_wr_addr,
    input  bank_data_t  cgra_wr_data,
    input  logic        cgra_rd_en,
    input  bank_addr_t  cgra_rd_addr,
    output bank_data_t  cgra_rd_data,

    // Configuration loader, read only.
    input  logic        cfg_rd_en,
    input  bank_addr_t  cfg_rd_addr,
    output bank_data_t  cfg_rd_data,

    bank_mem_if.controller mem
);

    glb_req_e   grant;            // Winner of the current cycle.
    glb_req_e   grant_q;          // Winner of the previous cycle.
    bank_data_t host_rd_data_q;   // Held host read data.
    bank_data_t cgra_rd_data_q;   // Held fabric read data.
    bank_data_t cfg_rd_data_q;    // Held config read data.

    // ==============================
    // Priority arbiter
    // ==============================
    // Losers are dropped without retry.
    always_comb begin
        if (host_wr_en)       grant = REQ_HOST_WR;
        else if (host_rd_en)  grant = REQ_HOST_RD;
        else if (cfg_rd_en)   grant = REQ_CFG_RD;
        else if (cgra_wr_en)  grant = REQ_CGRA_WR;
        else if (cgra_rd_en)  grant = REQ_CGRA_RD;
        else                  grant = REQ_NONE;
    end

    // Drive the memory port from the winner.
    always_comb begin
        mem.rd_en   = 1'b0;
        mem.wr_en   = 1'b0;
        mem.addr    = '0;
        mem.data_in = '0;  // Only meaningful on writes.
        case (grant)
            REQ_HOST_WR: begin
                mem.wr_en   = 1'b1;
                mem.addr    = host_wr_addr;
                mem.data_in = host_wr_data;
            end
            REQ_HOST_RD: begin
                mem.rd_en = 1'b1;
                mem.addr  = host_rd_addr;
            end
            REQ_CFG_RD: begin
                mem.rd_en = 1'b1;
                mem.addr  = cfg_rd_addr;
            end
            REQ_CGRA_WR: begin
                mem.wr_en   = 1'b1;
                mem.addr    = cgra_wr_addr;
                mem.data_in = cgra_wr_data;
            end
            REQ_CGRA_RD: begin
                mem.rd_en = 1'b1;
                mem.addr  = cgra_rd_addr;
            end
            default: ;  // Idle port.
        endcase
    end

    // ==============================
    // Read data routing and hold
    // ==============================
    // Grant is remembered one cycle so the returning word finds its owner.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            grant_q        <= REQ_NONE;
            host_rd_data_q <= '0;
            cgra_rd_data_q <= '0;
            cfg_rd_data_q  <= '0;
        end else begin
            grant_q        <= grant;
            host_rd_data_q <= host_rd_data;  // Capture what is shown.
            cgra_rd_data_q <= cgra_rd_data;
            cfg_rd_data_q  <= cfg_rd_data;
        end
    end

    // Only the read winner sees the fresh memory word.
    assign host_rd_data = (grant_q == REQ_HOST_RD) ? mem.data_out : host_rd_data_q;
    assign cgra_rd_data = (grant_q == REQ_CGRA_RD) ? mem.data_out : cgra_rd_data_q;
    assign cfg_rd_data  = (grant_q == REQ_CFG_RD)  ? mem.data_out : cfg_rd_data_q;

    // ==============================
    // Checks
    // ==============================
    // A read port moves only in the cycle after its own granted read.
    a_routed_is_read: assert property (@(posedge clk) disable iff (reset)
        ($stable(host_rd_data) || grant_q == REQ_HOST_RD)
        && ($stable(cgra_rd_data) || grant_q == REQ_CGRA_RD)
        && ($stable(cfg_rd_data) || grant_q == REQ_CFG_RD))
        else $error("read port changed without its own read grant");

endmodule

//--- verilog/bank_mem_if.sv
// Bank memory port.
// Single shared port between the bank controller and the memory core.

`timescale 1ns/10ps

interface bank_mem_if
    import glb_pkg::*;
();

    logic       rd_en;     // Read strobe, one cycle per read.
    logic       wr_en;     // Write strobe.
    bank_addr_t addr;      // Word address for either access.
    bank_data_t data_in;   // Write data.
    bank_data_t data_out;  // Read data, valid after the grant edge.

    // Controller side drives the access.
    modport controller (
        output rd_en,
        output wr_en,
        output addr,
        output data_in,
        input  data_out
    );

    // Memory side returns read data.
    modport memory (
        input  rd_en,
        input  wr_en,
        input  addr,
        input  data_in,
        output data_out
    );

endinterface

//--- verilog/bank_memory.sv
// Bank memory core.
// Single-port synchronous word memory with one cycle of read latency.
// Read data holds between reads.

`timescale 1ns/10ps

module bank_memory
    import glb_pkg::*;
(
    input  logic       clk,
    bank_mem_if.memory mem
);

    // ==============================
    // Storage
    // ==============================
    localparam int MEM_DEPTH = 2 ** BANK_ADDR_WIDTH;  // 1024 words.

    bank_data_t mem_array [MEM_DEPTH];  // Word storage, no reset.

    // ==============================
    // Write port
    // ==============================
    // Commits at the edge that ends the grant cycle.
    always_ff @(posedge clk) begin
        if (mem.wr_en) begin
            mem_array[mem.addr] <= mem.data_in;
        end
    end

    // ==============================
    // Read port
    // ==============================
    // Registered output, unchanged on idle and write cycles.
    always_ff @(posedge clk) begin
        if (mem.rd_en) begin
            mem.data_out <= mem_array[mem.addr];
        end
    end

    // ==============================
    // Checks
    // ==============================
    // The controller must never drive both strobes.
    a_no_rd_wr: assert property (@(posedge clk)
        mem.wr_en |-> !mem.rd_en)
        else $error("read and write in the same cycle");

endmodule

//--- verilog/glb_bank.sv
// Global buffer bank.
// Host, config loader and CGRA fabric share one memory core
// through a fixed-priority bank controller.

`timescale 1ns/10ps

module glb_bank
    import glb_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    // ==============================
    // Host
    // ==============================
    input  logic       host_wr_en,
    input  bank_addr_t host_wr_addr,
    input  bank_data_t host_wr_data,
    input  logic       host_rd_en,
    input  bank_addr_t host_rd_addr,
    output bank_data_t host_rd_data,

    // ==============================
    // CGRA fabric
    // ==============================
    input  logic       cgra_wr_en,
    input  bank_addr_t cgra_wr_addr,
    input  bank_data_t cgra_wr_data,
    input  logic       cgra_rd_en,
    input  bank_addr_t cgra_rd_addr,
    output bank_data_t cgra_rd_data,

    // ==============================
    // Configuration loader
    // ==============================
    input  logic       cfg_rd_en,
    input  bank_addr_t cfg_rd_addr,
    output bank_data_t cfg_rd_data
);

    // Shared memory port.
    bank_mem_if mem_if0 ();

    // Arbiter and read data return.
    bank_controller ctrl0 (
        .clk          (clk),
        .reset        (reset),
        .host_wr_en   (host_wr_en),
        .host_wr_addr (host_wr_addr),
        .host_wr_data (host_wr_data),
        .host_rd_en   (host_rd_en),
        .host_rd_addr (host_rd_addr),
        .host_rd_data (host_rd_data),
        .cgra_wr_en   (cgra_wr_en),
        .cgra_wr_addr (cgra_wr_addr),
        .cgra_wr_data (cgra_wr_data),
        .cgra_rd_en   (cgra_rd_en),
        .cgra_rd_addr (cgra_rd_addr),
        .cgra_rd_data (cgra_rd_data),
        .cfg_rd_en    (cfg_rd_en),
        .cfg_rd_addr  (cfg_rd_addr),
        .cfg_rd_data  (cfg_rd_data),
        .mem          (mem_if0.controller)
    );

    // Memory core, one cycle read latency.
    bank_memory mem0 (
        .clk (clk),
        .mem (mem_if0.memory)
    );

endmodule

//--- verilog/glb_pkg.sv
// Global buffer bank definitions.
// Word and address widths, their vector types, and the requester
// encoding shared by the controller, the memory core and the testbench.

package glb_pkg;

    // ==============================
    // Bank geometry
    // ==============================
    localparam int BANK_DATA_WIDTH = 64;  // Bits per memory word.
    localparam int BANK_ADDR_WIDTH = 10;  // Word address, 1024 words deep.

    typedef logic [BANK_DATA_WIDTH-1:0] bank_data_t;  // Every data path.
    typedef logic [BANK_ADDR_WIDTH-1:0] bank_addr_t;  // Every word address.

    // ==============================
    // Port owner per cycle
    // ==============================
    // Listed in grant priority order after REQ_NONE.
    typedef enum logic [2:0] {
        REQ_NONE    = 3'd0,  // Memory port idle.
        REQ_HOST_WR = 3'd1,  // Host write, highest priority.
        REQ_HOST_RD = 3'd2,  // Host read.
        REQ_CFG_RD  = 3'd3,  // Configuration loader read.
        REQ_CGRA_WR = 3'd4,  // Fabric write.
        REQ_CGRA_RD = 3'd5   // Fabric read, lowest priority.
    } glb_req_e;

endpackage
